// File: list.f
source/io_cfg_pkg.sv
source/jtag_pkg.sv
source/io_pad.sv
source/io_input_sync.sv
source/jtag_overlay.sv
source/io_ring_top.sv
bench/io_ring_asserts.sv
bench/io_ring_tb.sv

// File: Makefile
# Verilator build and run for the I/O ring testbench
# Override any variable on the command line, e.g. make BUILD_DIR=build

VERILATOR  ?= verilator
TOP        ?= io_ring_tb
RTL_TOP    ?= io_ring_top
FILE_LIST  ?= list.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		source/io_cfg_pkg.sv source/jtag_pkg.sv source/io_pad.sv \
		source/io_input_sync.sv source/jtag_overlay.sv source/io_ring_top.sv

clean:
	rm -rf $(BUILD_DIR)

// File: bench/io_ring_tb.sv
//////////////////////////////
// Testbench for the I/O ring top level
// Random core and pad stimulus checked every cycle against a model
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module io_ring_tb;

  import io_cfg_pkg::*;
  import jtag_pkg::*;

  localparam pad_variant_vec_t pad_variants = {
    pad_open_drain, pad_open_drain, pad_open_drain,              // Pads 15..13
    pad_bidir, pad_bidir, pad_bidir, pad_bidir, pad_bidir, pad_bidir,  // 12..7
    pad_open_drain,                                              // Pad 6
    pad_input_only, pad_input_only,                              // Pads 5..4
    pad_bidir, pad_bidir, pad_bidir, pad_bidir                   // Pads 3..0
  };
  localparam pad_vec_t    tie_off_values = 16'h0400;  // Trst held inactive
  localparam pad_idx_t    en_idx         = 4'd7;
  localparam pad_idx_t    tck_idx        = 4'd8;
  localparam pad_idx_t    tms_idx        = 4'd9;
  localparam pad_idx_t    trst_idx       = 4'd10;
  localparam pad_idx_t    tdi_idx        = 4'd11;
  localparam pad_idx_t    tdo_idx        = 4'd12;
  localparam int unsigned reset_cycles   = 5;
  localparam int unsigned reset_timeout  = 20;        // Cycles allowed for release
  localparam int unsigned phase_cycles   = 100;

  logic          clk;
  logic          reset;
  pad_vec_t      core_out;
  pad_vec_t      core_oe;
  pad_vec_t      core_in;
  pad_attr_vec_t core_attr;
  jtag_t         jtag;
  logic          jtag_tdo;
  pad_vec_t      pad_out;
  pad_vec_t      pad_oe;
  pad_vec_t      pad_in;

  logic [31:0] rng_state;    // Xorshift state
  pad_vec_t    hist_q1;      // Model of the input path, one edge back
  pad_vec_t    hist_q2;      // Two edges back, what the core sees
  int unsigned error_count;

  io_ring_top #(
    .NumPads      ( num_pads       ),
    .PadVariants  ( pad_variants   ),
    .TieOffValues ( tie_off_values ),
    .JtagEnIdx    ( en_idx         ),
    .TckIdx       ( tck_idx        ),
    .TmsIdx       ( tms_idx        ),
    .TrstIdx      ( trst_idx       ),
    .TdiIdx       ( tdi_idx        ),
    .TdoIdx       ( tdo_idx        )
  ) io_ring_top_i (
    .clk_i       ( clk       ),
    .reset_i     ( reset     ),
    .core_out_i  ( core_out  ),
    .core_oe_i   ( core_oe   ),
    .core_in_o   ( core_in   ),
    .core_attr_i ( core_attr ),
    .jtag_o      ( jtag      ),
    .jtag_tdo_i  ( jtag_tdo  ),
    .pad_out_o   ( pad_out   ),
    .pad_oe_o    ( pad_oe    ),
    .pad_in_i    ( pad_in    )
  );

  bind io_ring_top io_ring_asserts #(
    .NumPads     ( NumPads     ),
    .PadVariants ( PadVariants ),
    .JtagEnIdx   ( JtagEnIdx   )
  ) io_ring_asserts_i (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .pad_out_i   ( pad_out_o   ),
    .pad_oe_i    ( pad_oe_o    ),
    .pad_in_i    ( pad_in_i    ),
    .core_attr_i ( core_attr_i ),
    .jtag_i      ( jtag_o      )
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;  // 4 ns period

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
  end

  //////////////////////////////
  // Stimulus and model helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Level each pad hands to the synchronizer
  function automatic pad_vec_t raw_levels(input pad_vec_t pins, input pad_attr_vec_t attrs);
    pad_vec_t v;
    for (int i = 0; i < num_pads; i++) begin
      v[i] = pins[i] ^ attrs[i].invert;
    end
    return v;
  endfunction

  // Mode 0 holds enable low, 1 holds it high, 2 leaves it random
  task automatic drive_random(input int mode);
    rng_state = xorshift32(rng_state);
    core_out  = rng_state[15:0];
    core_oe   = rng_state[31:16];
    rng_state = xorshift32(rng_state);
    core_attr = rng_state;
    rng_state = xorshift32(rng_state);
    pad_in    = rng_state[15:0];
    jtag_tdo  = rng_state[16];
    if (mode != 2) begin
      core_attr[en_idx].invert = 1'b0;
      pad_in[en_idx]           = (mode == 1);
    end
  endtask

  task automatic expected_pads(input logic en, output pad_vec_t exp_out,
                               output pad_vec_t exp_oe);
    pad_vec_t want_out;
    pad_vec_t want_oe;
    logic     lvl;
    want_out = core_out;
    want_oe  = core_oe;
    if (en) begin
      want_out[tdo_idx] = jtag_tdo;  // TDO takes its pad
      want_oe[tdo_idx]  = 1'b1;
      want_oe[tck_idx]  = 1'b0;
      want_oe[tms_idx]  = 1'b0;
      want_oe[trst_idx] = 1'b0;
      want_oe[tdi_idx]  = 1'b0;
    end
    for (int i = 0; i < num_pads; i++) begin
      lvl = want_out[i] ^ core_attr[i].invert;
      if (pad_variants[i] == pad_input_only) begin
        exp_out[i] = 1'b0;
        exp_oe[i]  = 1'b0;
      end else if (pad_variants[i] == pad_open_drain) begin
        exp_out[i] = 1'b0;                // Low only, high is released
        exp_oe[i]  = want_oe[i] & ~lvl;
      end else begin
        exp_out[i] = lvl;
        exp_oe[i]  = want_oe[i];
      end
    end
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic stop_with_failure();
    error_count++;
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic compare_pads(input string test, input string what, input pad_vec_t exp,
                              input pad_vec_t act);
    if (act !== exp) begin
      $display("[FAIL] %s %s expected %h actual %h", test, what, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_core_in(input string test, input pad_vec_t exp, input pad_vec_t act);
    if (act !== exp) begin
      $display("[FAIL] %s core_in_o expected %h actual %h", test, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic verify_jtag(input string test, input jtag_t exp, input jtag_t act);
    if (act !== exp) begin
      $display("[FAIL] %s jtag_o expected %b actual %b", test, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic wait_reset_release();
    int unsigned cycles;
    cycles = 0;
    @(negedge clk);
    while (reset) begin
      if (cycles == reset_timeout) begin
        $display("Reset was not released within %0d cycles", reset_timeout);
        stop_with_failure();
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  // Model steps at the edge, inputs change 1 ns later, outputs checked at the falling edge
  task automatic run_cycle(input string test, input int mode);
    pad_vec_t exp_out;
    pad_vec_t exp_oe;
    pad_vec_t exp_in;
    jtag_t    exp_jtag;
    logic     en;
    @(posedge clk);
    hist_q2 = hist_q1;
    hist_q1 = raw_levels(pad_in, core_attr);
    #1;
    drive_random(mode);
    @(negedge clk);
    en       = hist_q2[en_idx];  // Overlay follows the synchronized strap
    exp_in   = hist_q2;
    exp_jtag = '0;
    if (en) begin
      exp_in[tck_idx]  = tie_off_values[tck_idx];
      exp_in[tms_idx]  = tie_off_values[tms_idx];
      exp_in[trst_idx] = tie_off_values[trst_idx];
      exp_in[tdi_idx]  = tie_off_values[tdi_idx];
      exp_in[tdo_idx]  = tie_off_values[tdo_idx];
      exp_jtag.tck     = hist_q2[tck_idx];
      exp_jtag.tms     = hist_q2[tms_idx];
      exp_jtag.trst_n  = hist_q2[trst_idx];
      exp_jtag.tdi     = hist_q2[tdi_idx];
    end
    expected_pads(en, exp_out, exp_oe);
    compare_pads(test, "pad_out_o", exp_out, pad_out);
    compare_pads(test, "pad_oe_o", exp_oe, pad_oe);
    check_core_in(test, exp_in, core_in);
    verify_jtag(test, exp_jtag, jtag);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    rng_state   = 32'hd0e983c9;
    error_count = 0;
    hist_q1     = '0;  // Synchronizer cleared by reset
    hist_q2     = '0;
    core_out    = '0;
    core_oe     = '0;
    core_attr   = '0;
    jtag_tdo    = 1'b0;
    pad_in      = '1;  // All pads high while reset holds the flops at zero
    wait_reset_release();
    check_core_in("reset", '0, core_in);
    verify_jtag("reset", '0, jtag);
    repeat (phase_cycles) run_cycle("jtag_off", 0);
    repeat (phase_cycles) run_cycle("jtag_on", 1);
    repeat (phase_cycles) run_cycle("jtag_off_again", 0);
    repeat (4 * phase_cycles) run_cycle("random_enable", 2);
    if (error_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// File: bench/io_ring_asserts.sv
//////////////////////////////
// Concurrent checks on the I/O ring outputs
// Bound into the ring top level by the testbench
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module io_ring_asserts #(
  parameter int unsigned                  NumPads     = io_cfg_pkg::num_pads,
  parameter io_cfg_pkg::pad_variant_vec_t PadVariants = '0,
  parameter jtag_pkg::pad_idx_t           JtagEnIdx   = 4'd7
) (
  input logic                      clk_i,
  input logic                      reset_i,
  input io_cfg_pkg::pad_vec_t      pad_out_i,    // Pad driver levels
  input io_cfg_pkg::pad_vec_t      pad_oe_i,     // Pad driver enables
  input io_cfg_pkg::pad_vec_t      pad_in_i,     // Raw receiver levels
  input io_cfg_pkg::pad_attr_vec_t core_attr_i,
  input jtag_pkg::jtag_t           jtag_i
);

  import io_cfg_pkg::*;

  logic en_seen_q;  // Strap level high at some edge since reset

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      en_seen_q <= 1'b0;
    end else if (pad_in_i[JtagEnIdx] ^ core_attr_i[JtagEnIdx].invert) begin
      en_seen_q <= 1'b1;
    end
  end

  for (genvar i = 0; i < NumPads; i++) begin : g_pad_chk
    if (PadVariants[i] == pad_input_only) begin : g_in_only
      input_only_no_oe: assert property (@(posedge clk_i) !pad_oe_i[i])
        else $error("Input-only pad %0d has its driver enabled", i);
    end
    if (PadVariants[i] == pad_open_drain) begin : g_open_drain
      open_drain_no_high: assert property (@(posedge clk_i) !(pad_oe_i[i] && pad_out_i[i]))
        else $error("Open-drain pad %0d drives a high level", i);
    end
  end

  jtag_idle_until_enable: assert property (
    @(posedge clk_i) disable iff (reset_i) (jtag_i != '0) |-> en_seen_q
  ) else $error("JTAG port active before the enable pad was seen high");

endmodule

`default_nettype wire

// File: source/io_ring_top.sv
//////////////////////////////
// I/O ring top level
// Overlay mux, row of pad cells and input synchronizer
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module io_ring_top #(
  parameter int unsigned                  NumPads      = io_cfg_pkg::num_pads,
  parameter io_cfg_pkg::pad_variant_vec_t PadVariants  = '0,  // All bidir
  parameter io_cfg_pkg::pad_vec_t         TieOffValues = '0,
  parameter jtag_pkg::pad_idx_t           JtagEnIdx    = 4'd7,
  parameter jtag_pkg::pad_idx_t           TckIdx       = 4'd8,
  parameter jtag_pkg::pad_idx_t           TmsIdx       = 4'd9,
  parameter jtag_pkg::pad_idx_t           TrstIdx      = 4'd10,
  parameter jtag_pkg::pad_idx_t           TdiIdx       = 4'd11,
  parameter jtag_pkg::pad_idx_t           TdoIdx       = 4'd12
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  // Core side
  input  io_cfg_pkg::pad_vec_t      core_out_i,
  input  io_cfg_pkg::pad_vec_t      core_oe_i,
  output io_cfg_pkg::pad_vec_t      core_in_o,
  input  io_cfg_pkg::pad_attr_vec_t core_attr_i,
  // JTAG
  output jtag_pkg::jtag_t           jtag_o,
  input  logic                      jtag_tdo_i,
  // Pad boundary
  output io_cfg_pkg::pad_vec_t      pad_out_o,
  output io_cfg_pkg::pad_vec_t      pad_oe_o,
  input  io_cfg_pkg::pad_vec_t      pad_in_i
);

  import io_cfg_pkg::*;

  pad_vec_t ring_out;   // Overlay to pads
  pad_vec_t ring_oe;
  pad_vec_t ring_raw;   // De-inverted pad inputs
  pad_vec_t ring_sync;  // After two flops

  //////////////////////////////
  // JTAG overlay
  //////////////////////////////

  jtag_overlay #(
    .NumPads      ( NumPads      ),
    .TieOffValues ( TieOffValues ),
    .JtagEnIdx    ( JtagEnIdx    ),
    .TckIdx       ( TckIdx       ),
    .TmsIdx       ( TmsIdx       ),
    .TrstIdx      ( TrstIdx      ),
    .TdiIdx       ( TdiIdx       ),
    .TdoIdx       ( TdoIdx       )
  ) jtag_overlay_i (
    .core_out_i ( core_out_i ),
    .core_oe_i  ( core_oe_i  ),
    .core_in_o  ( core_in_o  ),
    .ring_out_o ( ring_out   ),
    .ring_oe_o  ( ring_oe    ),
    .ring_in_i  ( ring_sync  ),
    .jtag_o     ( jtag_o     ),
    .jtag_tdo_i ( jtag_tdo_i )
  );

  //////////////////////////////
  // Pad cells
  //////////////////////////////

  for (genvar i = 0; i < NumPads; i++) begin : g_pad
    io_pad #(
      .Variant ( PadVariants[i] )  // Per-pad flavour
    ) io_pad_i (
      .out_i     ( ring_out[i]    ),
      .oe_i      ( ring_oe[i]     ),
      .attr_i    ( core_attr_i[i] ),
      .pad_out_o ( pad_out_o[i]   ),
      .pad_oe_o  ( pad_oe_o[i]    ),
      .pad_in_i  ( pad_in_i[i]    ),
      .in_o      ( ring_raw[i]    )
    );
  end

  //////////////////////////////
  // Input synchronizer
  //////////////////////////////

  io_input_sync #(
    .NumPads ( NumPads )
  ) io_input_sync_i (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .async_i ( ring_raw  ),
    .sync_o  ( ring_sync )
  );

endmodule

`default_nettype wire

// File: source/jtag_overlay.sv
//////////////////////////////
// JTAG overlay mux between core and pad ring
// Synchronized enable pad hands five pads to the JTAG port
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module jtag_overlay #(
  parameter int unsigned          NumPads      = io_cfg_pkg::num_pads,
  parameter io_cfg_pkg::pad_vec_t TieOffValues = '0,     // Core view while active
  parameter jtag_pkg::pad_idx_t   JtagEnIdx    = 4'd7,   // Enable strap pad
  parameter jtag_pkg::pad_idx_t   TckIdx       = 4'd8,
  parameter jtag_pkg::pad_idx_t   TmsIdx       = 4'd9,
  parameter jtag_pkg::pad_idx_t   TrstIdx      = 4'd10,
  parameter jtag_pkg::pad_idx_t   TdiIdx       = 4'd11,
  parameter jtag_pkg::pad_idx_t   TdoIdx       = 4'd12
) (
  // Core side
  input  io_cfg_pkg::pad_vec_t core_out_i,
  input  io_cfg_pkg::pad_vec_t core_oe_i,
  output io_cfg_pkg::pad_vec_t core_in_o,
  // Ring side
  output io_cfg_pkg::pad_vec_t ring_out_o,
  output io_cfg_pkg::pad_vec_t ring_oe_o,
  input  io_cfg_pkg::pad_vec_t ring_in_i,   // Already synchronized
  // JTAG port
  output jtag_pkg::jtag_t      jtag_o,
  input  logic                 jtag_tdo_i
);

  import io_cfg_pkg::*;
  import jtag_pkg::*;

  logic     jtag_en;        // Overlay active
  pad_vec_t jtag_pad_mask;  // Pads owned by JTAG
  jtag_t    jtag_pins;      // Pad levels for the JTAG port

  assign jtag_en = ring_in_i[JtagEnIdx];  // Active-high strap, after sync

  //////////////////////////////
  // Pads taken by the overlay
  //////////////////////////////

  always_comb begin
    jtag_pad_mask          = '0;
    jtag_pad_mask[TckIdx]  = 1'b1;
    jtag_pad_mask[TmsIdx]  = 1'b1;
    jtag_pad_mask[TrstIdx] = 1'b1;
    jtag_pad_mask[TdiIdx]  = 1'b1;
    jtag_pad_mask[TdoIdx]  = 1'b1;  // Enable pad stays with the core
  end

  //////////////////////////////
  // Output side
  //////////////////////////////

  always_comb begin
    ring_out_o = core_out_i;  // Default pass-through
    ring_oe_o  = core_oe_i;
    if (jtag_en) begin
      ring_out_o[TdoIdx] = jtag_tdo_i;  // TDO owns its pad
      ring_oe_o[TdoIdx]  = 1'b1;
      ring_oe_o[TckIdx]  = 1'b0;        // JTAG inputs are receive only
      ring_oe_o[TmsIdx]  = 1'b0;
      ring_oe_o[TrstIdx] = 1'b0;
      ring_oe_o[TdiIdx]  = 1'b0;
    end
  end

  //////////////////////////////
  // Input side
  //////////////////////////////

  always_comb begin
    jtag_pins.tck    = ring_in_i[TckIdx];
    jtag_pins.tms    = ring_in_i[TmsIdx];
    jtag_pins.trst_n = ring_in_i[TrstIdx];
    jtag_pins.tdi    = ring_in_i[TdiIdx];
  end

  assign jtag_o = jtag_en ? jtag_pins : '0;  // Idle port reads all zeros

  always_comb begin
    core_in_o = ring_in_i;
    for (int i = 0; i < NumPads; i++) begin
      if (jtag_en && jtag_pad_mask[i]) begin
        core_in_o[i] = TieOffValues[i];  // Core sees fixed level
      end
    end
  end

endmodule

`default_nettype wire

// File: source/io_input_sync.sv
//////////////////////////////
// Two-flop synchronizer for pad inputs
// Brings every pad level into the clk_i domain
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module io_input_sync #(
  parameter int unsigned NumPads = io_cfg_pkg::num_pads
) (
  input  logic                 clk_i,
  input  logic                 reset_i,  // Sync, active high
  input  io_cfg_pkg::pad_vec_t async_i,  // Raw pad levels
  output io_cfg_pkg::pad_vec_t sync_o    // Two edges later
);

  import io_cfg_pkg::*;

  pad_vec_t sync_q1;  // First stage, may be metastable
  pad_vec_t sync_q2;  // Second stage, stable

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      for (int i = 0; i < NumPads; i++) begin
        sync_q1[i] <= async_i[i];
        sync_q2[i] <= sync_q1[i];
      end
    end
  end

  assign sync_o = sync_q2;

endmodule

`default_nettype wire

// File: source/io_pad.sv
//////////////////////////////
// Single pad cell model
// Applies variant and invert rules to out, oe and in
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module io_pad #(
  parameter io_cfg_pkg::pad_variant_t Variant = io_cfg_pkg::pad_bidir
) (
  input  logic                  out_i,      // Core level to drive
  input  logic                  oe_i,       // Core output enable
  input  io_cfg_pkg::pad_attr_t attr_i,
  output logic                  pad_out_o,  // Level at the pad
  output logic                  pad_oe_o,   // Driver enable at the pad
  input  logic                  pad_in_i,   // Raw receiver level
  output logic                  in_o        // Level back toward the core
);

  import io_cfg_pkg::*;

  logic out_inv;  // Output level after invert

  assign out_inv = out_i ^ attr_i.invert;

  //////////////////////////////
  // Driver
  //////////////////////////////

  always_comb begin
    unique case (Variant)
      pad_bidir: begin
        pad_out_o = out_inv;
        pad_oe_o  = oe_i;
      end
      pad_open_drain: begin
        pad_out_o = 1'b0;              // Only ever pulls low
        pad_oe_o  = oe_i & ~out_inv;   // High means release
      end
      default: begin
        pad_out_o = 1'b0;              // Input-only, driver off
        pad_oe_o  = 1'b0;
      end
    endcase
  end

  // Receiver path, same for all variants
  assign in_o = pad_in_i ^ attr_i.invert;

endmodule

`default_nettype wire

// File: source/jtag_pkg.sv
//////////////////////////////
// JTAG port bundle and pad index type
// Used by the overlay mux and its placement parameters
//////////////////////////////
`default_nettype none

package jtag_pkg;

  // Index of a pad in the ring, wide enough for 16 pads
  typedef logic [3:0] pad_idx_t;

  //////////////////////////////
  // JTAG inputs from the pads
  //////////////////////////////

  typedef struct packed {
    logic tck;     // Test clock, sampled as a level
    logic tms;     // Mode select
    logic trst_n;  // Test reset, active low
    logic tdi;     // Serial data in
  } jtag_t;

endpackage

`default_nettype wire

// File: source/io_cfg_pkg.sv
//////////////////////////////
// Pad ring configuration shared by the I/O ring RTL and bench
// Pad count, pad vectors, per-pad attributes and variant codes
//////////////////////////////
`default_nettype none

package io_cfg_pkg;

  //////////////////////////////
  // Ring size and vectors
  //////////////////////////////

  localparam int unsigned num_pads = 16;        // Pads in the flat ring

  typedef logic [num_pads-1:0] pad_vec_t;       // One bit per pad, out/oe/in

  //////////////////////////////
  // Per-pad attributes
  //////////////////////////////

  typedef struct packed {
    logic invert;                               // Flip level in both directions
    logic slew;                                 // Reserved, carried through only
  } pad_attr_t;

  typedef pad_attr_t [num_pads-1:0] pad_attr_vec_t;  // Attribute per pad

  //////////////////////////////
  // Pad variants
  //////////////////////////////

  typedef logic [1:0] pad_variant_t;            // Cell flavour code

  localparam pad_variant_t pad_bidir      = 2'd0;  // Drives whenever enabled
  localparam pad_variant_t pad_input_only = 2'd1;  // Receiver only
  localparam pad_variant_t pad_open_drain = 2'd3;  // Pulls low, never high

  typedef pad_variant_t [num_pads-1:0] pad_variant_vec_t;  // Variant per pad

endpackage

`default_nettype wire
